// File: Makefile
TOP = tb_tx_dma

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -f sim.f --top-module $(TOP) -o $(TOP)

run: compile
	@out="$$(./obj_dir/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Simulation passed"

clean:
	rm -rf obj_dir

// File: sim.f
verilog/txdma_pkg.sv
verilog/txdma_ifs.sv
verilog/dma_read_requester.sv
verilog/cpl_writer.sv
verilog/tx_buffer.sv
verilog/tx_stream_reader.sv
verilog/tx_dma_top.sv
tests/tb_tx_dma.sv

// File: tests/tb_tx_dma.sv
module tb_tx_dma;
    import txdma_pkg::*;

    // small buffer and chunk so the space and tag limits are actually reached
    localparam int BUF_AW         = 5;
    localparam int CHUNK_QWORDS   = 8;
    localparam int SKID_QWORDS    = 2;     // output skid of the stream reader
    localparam logic [63:0] BASE0 = 64'h0000_0001_2345_6000;
    localparam logic [63:0] BASE1 = 64'h0000_0000_8000_0f00;
    localparam int LEN0           = 40;
    localparam int LEN1           = 7;
    localparam int TOTAL          = LEN0 + LEN1;
    localparam int TIMEOUT_CYCLES = 20 * TOTAL + 2000;

    logic                trn_clk          = 1'b0;
    logic                reset            = 1'b1;
    logic                start_valid_i    = 1'b0;
    logic [63:0]         start_addr_i     = '0;
    logic [LEN_W-1:0]    start_qwords_i   = '0;
    logic                rd_req_ready_i   = 1'b0;
    logic [63:0]         trn_rd_i         = '0;
    logic                trn_rsof_n_i     = 1'b1;
    logic                trn_reof_n_i     = 1'b1;
    logic                trn_rsrc_rdy_n_i = 1'b1;
    logic                tx_ready_i       = 1'b0;
    logic                start_ready_o;
    logic                rd_req_valid_o;
    logic [63:0]         rd_req_addr_o;
    logic [BUF_AW:0]     rd_req_qwords_o;
    logic [TAG_W-1:0]    rd_req_tag_o;
    logic                tx_valid_o;
    logic [63:0]         tx_data_o;
    logic                page_done_o;

    int seed = 32'h3537;
    int rnd;
    int pick;
    int part;
    int frames = 0;
    int cycles = 0;
    int start_cnt = 0;
    int done_cnt = 0;
    int req_acc = 0;
    int cpl_done = 0;
    int q_req = 0;
    int out_cnt = 0;
    int req_left = 0;
    logic [63:0] req_next_addr = '0;
    logic [63:0] exp_tx_data;
    logic [66:0] beat;                 // {last piece, sof, eof, data}
    logic [66:0] beats [$];
    logic [63:0] pend_addr [$];
    int          pend_len [$];
    logic [TAG_W-1:0] pend_tag [$];

    tx_dma_top #(.BUF_AW(BUF_AW), .CHUNK_QWORDS(CHUNK_QWORDS)) DUT (.*);

    initial forever #4 trn_clk = ~trn_clk;

    function automatic logic [63:0] host_word(input logic [63:0] addr);
        return addr ^ 64'hA5A5_0000_0000_5A5A;
    endfunction

    function automatic logic [31:0] swap_bytes(input logic [31:0] d);
        return {d[7:0], d[15:8], d[23:16], d[31:24]};
    endfunction

    function automatic logic [63:0] expected_word(input int idx);
        if (idx < LEN0) begin
            return host_word(BASE0 + 64'(8 * idx));
        end
        return host_word(BASE1 + 64'(8 * (idx - LEN0)));
    endfunction

    assign exp_tx_data = expected_word(out_cnt);

    task automatic abort_run(input string line);
        $display("%s", line);
        $display("Simulation failed");
        $fatal(1);
    endtask

    // one completion for n qwords from addr, dwords swapped so the dut unswaps them
    task automatic queue_completion(input logic [TAG_W-1:0] tag, input logic [63:0] addr,
                                    input int n, input logic last);
        logic [63:0] d;
        logic [63:0] q;
        logic [63:0] q_next;
        logic [31:0] low;
        int k;
        d = '0;
        d[62:56] = CPLD;
        d[41:32] = 10'(2 * n);
        d[15:13] = SC;
        beats.push_back({3'b010, d});
        q = host_word(addr);
        d = '0;
        d[41:40] = tag;
        d[31:0] = swap_bytes(q[31:0]);
        beats.push_back({3'b000, d});
        for (k = 0; k < n; k++) begin
            q = host_word(addr + 64'(8 * k));
            q_next = host_word(addr + 64'(8 * (k + 1)));
            low = (k < n - 1) ? swap_bytes(q_next[31:0]) : 32'h0;
            beats.push_back({last && (k == n - 1), 1'b0, k == n - 1,
                             swap_bytes(q[63:32]), low});
        end
    endtask

    // mwr or ur frame, must be dropped whole
    task automatic add_junk_frame(input logic is_mwr, input logic [TAG_W-1:0] tag);
        logic [63:0] d;
        d = '0;
        d[62:56] = is_mwr ? MWR : CPLD;
        d[41:32] = 10'd4;
        d[15:13] = is_mwr ? SC : UR;
        beats.push_back({3'b010, d});
        beats.push_back({3'b000, 22'h0, tag, 40'hde_adbe_ef00});
        beats.push_back({3'b001, 64'hffff_0000_ffff_0000});
    endtask

    task automatic start_region(input logic [63:0] addr, input int len);
        @(posedge trn_clk);
        start_valid_i  <= 1'b1;
        start_addr_i   <= addr;
        start_qwords_i <= LEN_W'(len);
        do @(posedge trn_clk); while (!(start_valid_i && start_ready_o));
        start_valid_i <= 1'b0;
    endtask

    //////////////////////////////
    // host model
    //////////////////////////////
    always @(posedge trn_clk) begin
        if (!reset) begin
            rnd = $random(seed);
            rd_req_ready_i <= rnd[1:0] != 2'b00;
            // heavy stream back-pressure during the first region
            tx_ready_i <= (start_cnt < 2) ? (rnd[3:2] == 2'b00) : (rnd[3:2] != 2'b00);
            if (rd_req_valid_o && rd_req_ready_i) begin
                pend_addr.push_back(rd_req_addr_o);
                pend_len.push_back(int'(rd_req_qwords_o));
                pend_tag.push_back(rd_req_tag_o);
            end
            if (beats.size() == 0 && pend_addr.size() != 0 && rnd[4]) begin
                pick = $unsigned($random(seed)) % pend_addr.size();  // any tag order
                part = pend_len[pick];
                if (part > 1 && rnd[8]) begin
                    part = 1 + $unsigned($random(seed)) % (part - 1);
                end
                queue_completion(pend_tag[pick], pend_addr[pick], part,
                                 part == pend_len[pick]);
                frames = frames + 1;
                if (frames % 3 == 1) begin
                    add_junk_frame(frames % 2 == 1, pend_tag[pick]);
                end
                if (part == pend_len[pick]) begin
                    pend_addr.delete(pick);
                    pend_len.delete(pick);
                    pend_tag.delete(pick);
                end else begin
                    pend_addr[pick] = pend_addr[pick] + 64'(8 * part);
                    pend_len[pick]  = pend_len[pick] - part;
                end
            end
            if (beats.size() != 0 && rnd[7:5] != 3'b000) begin
                beat = beats.pop_front();
                trn_rd_i         <= beat[63:0];
                trn_rsof_n_i     <= !beat[65];
                trn_reof_n_i     <= !beat[64];
                trn_rsrc_rdy_n_i <= 1'b0;
                if (beat[66]) begin
                    cpl_done <= cpl_done + 1;
                end
            end else begin
                trn_rsof_n_i     <= 1'b1;
                trn_reof_n_i     <= 1'b1;
                trn_rsrc_rdy_n_i <= 1'b1;      // idle gap
            end
        end
    end

    //////////////////////////////
    // port counters and timeout
    //////////////////////////////
    always @(posedge trn_clk) begin
        cycles <= cycles + 1;
        if (cycles == TIMEOUT_CYCLES) begin
            abort_run($sformatf("timeout, run still busy after %0d cycles", TIMEOUT_CYCLES));
        end
        if (!reset) begin
            if (start_valid_i && start_ready_o) begin
                start_cnt     <= start_cnt + 1;
                req_next_addr <= start_addr_i;
                req_left      <= int'(start_qwords_i);
            end
            if (rd_req_valid_o && rd_req_ready_i) begin
                req_acc       <= req_acc + 1;
                q_req         <= q_req + int'(rd_req_qwords_o);
                req_next_addr <= req_next_addr + 64'(8 * int'(rd_req_qwords_o));
                req_left      <= req_left - int'(rd_req_qwords_o);
            end
            if (tx_valid_o && tx_ready_i) begin
                out_cnt <= out_cnt + 1;
            end
            if (page_done_o) begin
                done_cnt <= done_cnt + 1;
            end
        end
    end

    a_stream_data: assert property (@(posedge trn_clk) disable iff (reset)
        tx_valid_o && tx_ready_i |-> out_cnt < TOTAL && tx_data_o == exp_tx_data)
        else abort_run($sformatf("[FAIL] %0t: stream qword %0d is %h, expected %h",
                                 $time, out_cnt, tx_data_o, exp_tx_data));

    a_req_order: assert property (@(posedge trn_clk) disable iff (reset)
        rd_req_valid_o && rd_req_ready_i |-> rd_req_addr_o == req_next_addr &&
        int'(rd_req_qwords_o) != 0 && int'(rd_req_qwords_o) <= CHUNK_QWORDS &&
        int'(rd_req_qwords_o) <= req_left)
        else abort_run($sformatf("[FAIL] %0t: request addr %h size %0d, expected addr %h",
                                 $time, rd_req_addr_o, rd_req_qwords_o, req_next_addr));

    a_outstanding: assert property (@(posedge trn_clk) disable iff (reset)
        req_acc - cpl_done <= MAX_OUTSTANDING)
        else abort_run($sformatf("[FAIL] %0t: %0d requests outstanding",
                                 $time, req_acc - cpl_done));

    // qwords already read out of the buffer may still sit in the output skid
    a_no_overrun: assert property (@(posedge trn_clk) disable iff (reset)
        q_req - out_cnt <= 2 ** BUF_AW + SKID_QWORDS)
        else abort_run($sformatf("[FAIL] %0t: %0d qwords held, buffer overrun",
                                 $time, q_req - out_cnt));

    a_done_once: assert property (@(posedge trn_clk) disable iff (reset)
        page_done_o |-> req_left == 0 && done_cnt + 1 == start_cnt)
        else abort_run($sformatf("[FAIL] %0t: page done with %0d qwords unrequested",
                                 $time, req_left));

    a_done_before_start: assert property (@(posedge trn_clk) disable iff (reset)
        start_valid_i && start_ready_o |-> done_cnt == start_cnt)
        else abort_run($sformatf("[FAIL] %0t: start accepted before page done", $time));

    initial begin
        repeat (8) @(posedge trn_clk);
        reset <= 1'b0;
        start_region(BASE0, LEN0);
        while (done_cnt != 1) @(posedge trn_clk);
        start_region(BASE1, LEN1);
        while (done_cnt != 2 || out_cnt != TOTAL) @(posedge trn_clk);
        repeat (20) @(posedge trn_clk);    // catch stray pulses or extra qwords
        if (done_cnt == 2 && out_cnt == TOTAL) begin
            $display("Simulation passed");
            $finish;
        end else begin
            abort_run($sformatf("[FAIL] %0t: %0d page done pulses, %0d qwords out",
                                $time, done_cnt, out_cnt));
        end
    end

endmodule

// File: verilog/cpl_writer.sv
module cpl_writer #(
    parameter int BUF_AW = 6
) (
    input  logic                       trn_clk,
    input  logic                       reset,
    input  logic [txdma_pkg::QW_W-1:0] trn_rd_i,
    input  logic                       trn_rsof_n_i,
    input  logic                       trn_reof_n_i,
    input  logic                       trn_rsrc_rdy_n_i,
    tag_alloc_if.writer                alloc,
    buf_wr_if.writer                   wr,
    output logic                       retire_o
);
    import txdma_pkg::*;

    cpl_state_e                 state;
    logic                       beat;
    logic                       commit_now;
    logic [TAG_W-1:0]           cur_tag;
    logic [TAG_W-1:0]           wr_tag;
    logic [TAG_W-1:0]           rt_tag;         // oldest outstanding tag
    logic [BUF_AW-1:0]          cur_addr;
    logic [31:0]                carry;          // low dword of previous beat
    logic [BUF_AW-1:0]          next_addr [MAX_OUTSTANDING];
    logic [BUF_AW:0]            req_size  [MAX_OUTSTANDING];
    logic [BUF_AW:0]            rcvd      [MAX_OUTSTANDING];
    logic [MAX_OUTSTANDING-1:0] pending;

    function automatic logic [31:0] bswap(input logic [31:0] d);
        return {d[7:0], d[15:8], d[23:16], d[31:24]};
    endfunction

    assign beat       = !trn_rsrc_rdy_n_i;
    assign commit_now = pending[rt_tag] && (rcvd[rt_tag] == req_size[rt_tag]);
    assign retire_o   = wr.commit_valid;

    //////////////////////////////
    // per-tag tables
    //////////////////////////////
    always_ff @(posedge trn_clk) begin
        if (wr.wr_en) begin
            next_addr[wr_tag] <= wr.wr_addr + 1'b1;
            rcvd[wr_tag]      <= rcvd[wr_tag] + 1'b1;
        end
        if (alloc.alloc_valid) begin
            next_addr[alloc.alloc_tag] <= alloc.alloc_buf_addr[BUF_AW-1:0];
            req_size[alloc.alloc_tag]  <= alloc.alloc_qwords;
            rcvd[alloc.alloc_tag]      <= '0;
        end
    end

    //////////////////////////////
    // frame parse, write, commit
    //////////////////////////////
    always_ff @(posedge trn_clk) begin
        if (reset) begin
            state           <= HDR;
            wr.wr_en        <= 1'b0;
            wr.commit_valid <= 1'b0;
            pending         <= '0;
            rt_tag          <= '0;
        end else begin
            wr.wr_en         <= 1'b0;
            wr.commit_valid  <= commit_now;
            wr.commit_qwords <= req_size[rt_tag];
            if (commit_now) begin              // retire strictly in tag order
                pending[rt_tag] <= 1'b0;
                rt_tag          <= rt_tag + 1'b1;
            end
            if (alloc.alloc_valid) begin
                pending[alloc.alloc_tag] <= 1'b1;
            end
            case (state)
                HDR: begin
                    // anything else is dropped, its later beats carry no sof
                    if (beat && !trn_rsof_n_i && trn_rd_i[62:56] == CPLD &&
                        trn_rd_i[15:13] == SC) begin
                        state <= TAG;
                    end
                end
                TAG: begin
                    if (beat) begin
                        cur_tag  <= trn_rd_i[41:40];
                        cur_addr <= next_addr[trn_rd_i[41:40]];
                        carry    <= trn_rd_i[31:0];   // data dword 0
                        state    <= DATA;
                    end
                end
                DATA: begin
                    if (beat) begin
                        wr.wr_en   <= 1'b1;
                        wr.wr_addr <= cur_addr;
                        wr.wr_data <= {bswap(trn_rd_i[63:32]), bswap(carry)};
                        wr_tag     <= cur_tag;
                        cur_addr   <= cur_addr + 1'b1;
                        carry      <= trn_rd_i[31:0];
                        if (!trn_reof_n_i) begin
                            state <= HDR;
                        end
                    end
                end
                default: state <= HDR;
            endcase
        end
    end

    // host must never send more than was asked for
    a_no_overfill: assert property (@(posedge trn_clk) disable iff (reset)
        wr.wr_en |-> pending[wr_tag] && (rcvd[wr_tag] != req_size[wr_tag]));

endmodule

// File: verilog/dma_read_requester.sv
module dma_read_requester #(
    parameter int BUF_AW       = 6,
    parameter int CHUNK_QWORDS = 16
) (
    input  logic                          trn_clk,
    input  logic                          reset,
    input  logic                          start_valid_i,
    input  logic [txdma_pkg::HOST_AW-1:0] start_addr_i,
    input  logic [txdma_pkg::LEN_W-1:0]   start_qwords_i,
    output logic                          start_ready_o,
    output logic                          rd_req_valid_o,
    input  logic                          rd_req_ready_i,
    output logic [txdma_pkg::HOST_AW-1:0] rd_req_addr_o,
    output logic [BUF_AW:0]               rd_req_qwords_o,
    output logic [txdma_pkg::TAG_W-1:0]   rd_req_tag_o,
    input  logic [BUF_AW:0]               free_qwords_i,
    input  logic                          retire_i,
    output logic [BUF_AW:0]               reserve_ptr_o,
    output logic                          page_done_o,
    tag_alloc_if.requester                alloc
);
    import txdma_pkg::*;

    localparam logic [BUF_AW:0] CHUNK = (BUF_AW + 1)'(CHUNK_QWORDS);
    localparam int OUT_W = $clog2(MAX_OUTSTANDING + 1);

    req_state_e         state;
    logic [HOST_AW-1:0] cur_addr;
    logic [LEN_W-1:0]   remaining;
    logic [TAG_W-1:0]   next_tag;
    logic [BUF_AW:0]    reserve_ptr;
    logic [OUT_W-1:0]   outstanding;
    logic [OUT_W-1:0]   outstanding_nxt;
    logic [BUF_AW:0]    next_size;
    logic               accept;
    logic               room;

    assign next_size = (remaining < LEN_W'(CHUNK_QWORDS)) ? remaining[BUF_AW:0] : CHUNK;
    assign accept    = rd_req_valid_o && rd_req_ready_i;
    assign room      = (free_qwords_i >= next_size) &&
                       (outstanding < OUT_W'(MAX_OUTSTANDING));
    assign outstanding_nxt = outstanding + OUT_W'(accept) - OUT_W'(retire_i);

    assign start_ready_o   = (state == IDLE) && !page_done_o;
    assign rd_req_addr_o   = cur_addr;     // held while ISSUE
    assign rd_req_qwords_o = next_size;
    assign rd_req_tag_o    = next_tag;
    assign reserve_ptr_o   = reserve_ptr;

    assign alloc.alloc_valid    = accept;
    assign alloc.alloc_tag      = next_tag;
    assign alloc.alloc_buf_addr = reserve_ptr;
    assign alloc.alloc_qwords   = next_size;

    //////////////////////////////
    // request fsm
    //////////////////////////////
    always_ff @(posedge trn_clk) begin
        if (reset) begin
            state          <= IDLE;
            rd_req_valid_o <= 1'b0;
            page_done_o    <= 1'b0;
            remaining      <= '0;
            next_tag       <= '0;
            reserve_ptr    <= '0;
            outstanding    <= '0;
        end else begin
            page_done_o <= 1'b0;
            outstanding <= outstanding_nxt;
            case (state)
                IDLE: begin
                    if (start_valid_i && start_ready_o) begin
                        cur_addr  <= start_addr_i;
                        remaining <= start_qwords_i;
                        state     <= WAIT_ROOM;
                    end
                end
                WAIT_ROOM: begin
                    if (remaining == '0) begin
                        state <= DRAIN;            // empty region
                    end else if (room) begin
                        rd_req_valid_o <= 1'b1;
                        state          <= ISSUE;
                    end
                end
                ISSUE: begin
                    if (rd_req_ready_i) begin
                        rd_req_valid_o <= 1'b0;
                        cur_addr    <= cur_addr + HOST_AW'({next_size, 3'b000});
                        remaining   <= remaining - LEN_W'(next_size);
                        reserve_ptr <= reserve_ptr + next_size;
                        next_tag    <= next_tag + 1'b1;
                        state <= (remaining == LEN_W'(next_size)) ? DRAIN : WAIT_ROOM;
                    end
                end
                DRAIN: begin
                    if (outstanding_nxt == '0) begin
                        page_done_o <= 1'b1;       // cycle after last commit
                        state       <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    a_outstanding_max: assert property (@(posedge trn_clk) disable iff (reset)
        outstanding <= OUT_W'(MAX_OUTSTANDING));

    a_req_stable: assert property (@(posedge trn_clk) disable iff (reset)
        rd_req_valid_o && !rd_req_ready_i |=> rd_req_valid_o && $stable(rd_req_addr_o) &&
        $stable(rd_req_qwords_o) && $stable(rd_req_tag_o));

endmodule

// File: verilog/tx_buffer.sv
module tx_buffer #(
    parameter int BUF_AW = 6
) (
    input  logic                       trn_clk,
    input  logic                       reset,
    buf_wr_if.buffer                   wr,
    input  logic [BUF_AW:0]            reserve_ptr_i,
    output logic [BUF_AW:0]            free_qwords_o,
    input  logic                       rd_en_i,
    output logic                       rd_avail_o,
    output logic [txdma_pkg::QW_W-1:0] rd_data_o
);
    import txdma_pkg::*;

    localparam int DEPTH = 2 ** BUF_AW;

    logic [QW_W-1:0] mem [DEPTH];
    logic [BUF_AW:0] commit_ptr;    // one extra bit for wrap
    logic [BUF_AW:0] rd_ptr;

    always_ff @(posedge trn_clk) begin
        if (wr.wr_en) begin
            mem[wr.wr_addr] <= wr.wr_data;
        end
        if (rd_en_i) begin
            rd_data_o <= mem[rd_ptr[BUF_AW-1:0]];
        end
    end

    always_ff @(posedge trn_clk) begin
        if (reset) begin
            commit_ptr <= '0;
            rd_ptr     <= '0;
        end else begin
            if (wr.commit_valid) begin
                commit_ptr <= commit_ptr + wr.commit_qwords;
            end
            if (rd_en_i) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    assign rd_avail_o    = (commit_ptr != rd_ptr);
    // reserved but not yet read counts as used
    assign free_qwords_o = (BUF_AW + 1)'(DEPTH) - (reserve_ptr_i - rd_ptr);

    a_rd_avail: assert property (@(posedge trn_clk) disable iff (reset)
        rd_en_i |-> rd_avail_o);

endmodule

// File: verilog/tx_dma_top.sv
module tx_dma_top #(
    parameter int BUF_AW       = 6,
    parameter int CHUNK_QWORDS = 16
) (
    input  logic                          trn_clk,
    input  logic                          reset,
    // start command
    input  logic                          start_valid_i,
    input  logic [txdma_pkg::HOST_AW-1:0] start_addr_i,
    input  logic [txdma_pkg::LEN_W-1:0]   start_qwords_i,
    output logic                          start_ready_o,
    // read requests to the host
    output logic                          rd_req_valid_o,
    input  logic                          rd_req_ready_i,
    output logic [txdma_pkg::HOST_AW-1:0] rd_req_addr_o,
    output logic [BUF_AW:0]               rd_req_qwords_o,
    output logic [txdma_pkg::TAG_W-1:0]   rd_req_tag_o,
    // pcie receive stream, active low
    input  logic [txdma_pkg::QW_W-1:0]    trn_rd_i,
    input  logic                          trn_rsof_n_i,
    input  logic                          trn_reof_n_i,
    input  logic                          trn_rsrc_rdy_n_i,
    // qword stream out
    output logic                          tx_valid_o,
    input  logic                          tx_ready_i,
    output logic [txdma_pkg::QW_W-1:0]    tx_data_o,
    output logic                          page_done_o
);

    tag_alloc_if #(.BUF_AW(BUF_AW)) alloc_bus ();
    buf_wr_if    #(.BUF_AW(BUF_AW)) wr_bus ();

    logic [BUF_AW:0]            free_qwords;
    logic [BUF_AW:0]            reserve_ptr;
    logic                       retire;
    logic                       rd_en;
    logic                       rd_avail;
    logic [txdma_pkg::QW_W-1:0] rd_data;

    dma_read_requester #(.BUF_AW(BUF_AW), .CHUNK_QWORDS(CHUNK_QWORDS)) u_requester (
        .trn_clk(trn_clk), .reset(reset),
        .start_valid_i(start_valid_i), .start_addr_i(start_addr_i),
        .start_qwords_i(start_qwords_i), .start_ready_o(start_ready_o),
        .rd_req_valid_o(rd_req_valid_o), .rd_req_ready_i(rd_req_ready_i),
        .rd_req_addr_o(rd_req_addr_o), .rd_req_qwords_o(rd_req_qwords_o),
        .rd_req_tag_o(rd_req_tag_o), .free_qwords_i(free_qwords),
        .retire_i(retire), .reserve_ptr_o(reserve_ptr),
        .page_done_o(page_done_o), .alloc(alloc_bus.requester)
    );

    cpl_writer #(.BUF_AW(BUF_AW)) u_writer (
        .trn_clk(trn_clk), .reset(reset),
        .trn_rd_i(trn_rd_i), .trn_rsof_n_i(trn_rsof_n_i),
        .trn_reof_n_i(trn_reof_n_i), .trn_rsrc_rdy_n_i(trn_rsrc_rdy_n_i),
        .alloc(alloc_bus.writer), .wr(wr_bus.writer), .retire_o(retire)
    );

    tx_buffer #(.BUF_AW(BUF_AW)) u_buffer (
        .trn_clk(trn_clk), .reset(reset), .wr(wr_bus.buffer),
        .reserve_ptr_i(reserve_ptr), .free_qwords_o(free_qwords),
        .rd_en_i(rd_en), .rd_avail_o(rd_avail), .rd_data_o(rd_data)
    );

    tx_stream_reader #(.BUF_AW(BUF_AW)) u_reader (
        .trn_clk(trn_clk), .reset(reset),
        .rd_avail_i(rd_avail), .rd_en_o(rd_en), .rd_data_i(rd_data),
        .tx_valid_o(tx_valid_o), .tx_ready_i(tx_ready_i), .tx_data_o(tx_data_o)
    );

endmodule

// File: verilog/tx_stream_reader.sv
module tx_stream_reader #(
    parameter int BUF_AW = 6
) (
    input  logic                       trn_clk,
    input  logic                       reset,
    input  logic                       rd_avail_i,
    output logic                       rd_en_o,
    input  logic [txdma_pkg::QW_W-1:0] rd_data_i,
    output logic                       tx_valid_o,
    input  logic                       tx_ready_i,
    output logic [txdma_pkg::QW_W-1:0] tx_data_o
);
    import txdma_pkg::*;

    localparam int SKID_DEPTH = 2;

    logic [QW_W-1:0] skid [SKID_DEPTH];
    logic [1:0]      cnt;
    logic            wptr;
    logic            rptr;
    logic            inflight;    // read issued last cycle
    logic            pop;

    // skid plus reads in flight must fit well inside the buffer
    if (2 ** BUF_AW < 2 * SKID_DEPTH) begin : g_depth_chk
        $error("tx buffer too small for the output skid");
    end

    assign pop        = tx_valid_o && tx_ready_i;
    assign tx_valid_o = (cnt != 2'd0);
    assign tx_data_o  = skid[rptr];
    assign rd_en_o    = rd_avail_i && (({1'b0, cnt} + 3'(inflight)) < (3'd2 + 3'(pop)));

    always_ff @(posedge trn_clk) begin
        if (inflight) begin
            skid[wptr] <= rd_data_i;
        end
    end

    always_ff @(posedge trn_clk) begin
        if (reset) begin
            cnt      <= '0;
            wptr     <= 1'b0;
            rptr     <= 1'b0;
            inflight <= 1'b0;
        end else begin
            inflight <= rd_en_o;
            cnt      <= cnt + 2'(inflight) - 2'(pop);
            if (inflight) begin
                wptr <= ~wptr;
            end
            if (pop) begin
                rptr <= ~rptr;
            end
        end
    end

    a_tx_stable: assert property (@(posedge trn_clk) disable iff (reset)
        tx_valid_o && !tx_ready_i |=> tx_valid_o && $stable(tx_data_o));

endmodule

// File: verilog/txdma_ifs.sv
// request reservation, requester to completion writer
interface tag_alloc_if #(
    parameter int BUF_AW = 6
);
    import txdma_pkg::*;

    logic              alloc_valid;      // one cycle, with request accept
    logic [TAG_W-1:0]  alloc_tag;
    logic [BUF_AW:0]   alloc_buf_addr;   // reserve pointer, wraps
    logic [BUF_AW:0]   alloc_qwords;

    modport requester (output alloc_valid, alloc_tag, alloc_buf_addr, alloc_qwords);
    modport writer    (input  alloc_valid, alloc_tag, alloc_buf_addr, alloc_qwords);
endinterface

// buffer write and commit port
interface buf_wr_if #(
    parameter int BUF_AW = 6
);
    import txdma_pkg::*;

    logic              wr_en;
    logic [BUF_AW-1:0] wr_addr;
    logic [QW_W-1:0]   wr_data;
    logic              commit_valid;
    logic [BUF_AW:0]   commit_qwords;    // size of the retired request

    modport writer (output wr_en, wr_addr, wr_data, commit_valid, commit_qwords);
    modport buffer (input  wr_en, wr_addr, wr_data, commit_valid, commit_qwords);
endinterface

// File: verilog/txdma_pkg.sv
package txdma_pkg;

    localparam int TAG_W           = 2;
    localparam int MAX_OUTSTANDING = 4;   // one request in flight per tag
    localparam int QW_W            = 64;
    localparam int HOST_AW         = 64;
    localparam int LEN_W           = 16;  // region length in qwords

    // fmt/type field, beat 0 bits 62:56
    typedef enum logic [6:0] {
        CPLD = 7'b100_1010,
        MWR  = 7'b110_0000
    } tlp_fmt_type_e;

    // completion status, beat 0 bits 15:13
    typedef enum logic [2:0] {
        SC = 3'b000,
        UR = 3'b001,
        CA = 3'b100
    } cpl_status_e;

    typedef enum logic [1:0] {
        IDLE,
        WAIT_ROOM,   // waiting for buffer space or a free tag
        ISSUE,
        DRAIN        // all issued, waiting for retires
    } req_state_e;

    typedef enum logic [1:0] {
        HDR,
        TAG,
        DATA
    } cpl_state_e;

endpackage
